// File: hub75_gpu.f
common/gpu_pkg.sv
vram/vram.sv
vram/pixel_store.sv
rtl/row_buffer.sv
rtl/scan_control.sv
hub75/hub75_driver.sv
rtl/hub75_gpu.sv
tests/hub75_gpu_tb.sv

// File: tests/hub75_gpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hub75_gpu_tb
  import gpu_pkg::*;
();

  localparam int CLK_HALF     = 20;
  localparam int RAND_SEED    = 37271;
  localparam int PH1_LEN      = 29;   // image and overlay writes, pattern off
  localparam int TBL_LEN      = 30;
  localparam int FRAME_CYCLES = SCAN_ROWS * (131 + 3 * 131 + BASE_ON * 7 + 3);
  localparam int CYCLE_LIMIT  = TBL_LEN + 3 * FRAME_CYCLES + 100;

  typedef struct packed {
    coord_t row;
    coord_t col;
    pixel_t px;
    logic   ovl;
    logic   pal;
  } wr_entry_t;

  logic      clk;
  logic      rst;
  logic      write;
  pixel_t    px_data;
  coord_t    column;
  coord_t    row;
  logic      image_palette;
  logic      image_overlay;
  rgb_t      rgb0;
  rgb_t      rgb1;
  logic      screen_clk;
  scan_row_t abcde;
  logic      latch;
  logic      oe_n;

  wr_entry_t tbl [0:TBL_LEN-1];
  pixel_t    model_img [0:VRAM_DEPTH-1];
  pixel_t    model_ovl [0:VRAM_DEPTH-1];
  logic      model_pattern;
  int        cycle_cnt = 0;
  int        err_cnt = 0;

  hub75_gpu u_hub75_gpu (
    .clk           (clk),
    .rst           (rst),
    .write         (write),
    .px_data       (px_data),
    .column        (column),
    .row           (row),
    .image_palette (image_palette),
    .image_overlay (image_overlay),
    .rgb0          (rgb0),
    .rgb1          (rgb1),
    .screen_clk    (screen_clk),
    .abcde         (abcde),
    .latch         (latch),
    .oe_n          (oe_n)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the panel scan did not finish", cycle_cnt);
      $display("Errors found");
      $fatal(1);
    end
  end

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic stop_run();
    err_cnt++;
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_row(input string name, input scan_row_t exp, input scan_row_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // reference model of the panel image
  // ----------------------------------------------------------------------
  function automatic pixel_t fused_pixel(input int r, input int c);
    int     addr;
    coord_t rr;
    coord_t cc;
    addr = r * PANEL_COLS + c;
    rr   = coord_t'(r);
    cc   = coord_t'(c);
    if (model_ovl[addr] != 8'h00) begin
      return model_ovl[addr];  // nonzero overlay wins
    end
    if (model_pattern) begin
      return {rr[2:0], cc[4:0]};
    end
    return model_img[addr];
  endfunction

  function automatic rgb_t expected_rgb(input pixel_t px, input int p);
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
    logic       b;
    red   = px[7:5];
    green = px[4:2];
    blue  = px[1:0];
    if (p == 0) begin
      b = 1'b0;
    end else begin
      b = blue[p-1];  // blue has only two bits
    end
    return {b, green[p], red[p]};
  endfunction

  task automatic set_entry(input int idx, input int r, input int c, input pixel_t px,
                           input logic ovl, input logic pal);
    tbl[idx].row = coord_t'(r);
    tbl[idx].col = coord_t'(c);
    tbl[idx].px  = px;
    tbl[idx].ovl = ovl;
    tbl[idx].pal = pal;
  endtask

  task automatic fill_table();
    set_entry(0, 0, 0, 8'hff, 1'b0, 1'b0);    // corners
    set_entry(1, 0, 63, 8'he0, 1'b0, 1'b0);
    set_entry(2, 63, 0, 8'h1c, 1'b0, 1'b0);
    set_entry(3, 63, 63, 8'h03, 1'b0, 1'b0);
    set_entry(4, 31, 32, 8'ha5, 1'b0, 1'b0);  // edges of the two halves
    set_entry(5, 32, 31, 8'h5a, 1'b0, 1'b0);
    set_entry(6, 10, 20, 8'h24, 1'b0, 1'b0);
    set_entry(7, 42, 20, 8'h92, 1'b0, 1'b0);
    for (int i = 0; i < 16; i++) begin
      set_entry(8 + i, (i * 7 + 3) % 64, (i * 11 + 5) % 64, pixel_t'($urandom), 1'b0, 1'b0);
    end
    set_entry(24, 0, 0, 8'h49, 1'b1, 1'b0);   // covers the image pixel
    set_entry(25, 10, 20, 8'hc3, 1'b1, 1'b0);
    set_entry(26, 10, 20, 8'h00, 1'b1, 1'b0); // transparent again
    set_entry(27, 5, 5, 8'h01, 1'b1, 1'b0);
    set_entry(28, 63, 63, 8'h80, 1'b1, 1'b0);
    set_entry(29, 20, 40, 8'h3f, 1'b1, 1'b1); // pattern background from here on
  endtask

  // ----------------------------------------------------------------------
  // stimulus and monitor
  // ----------------------------------------------------------------------
  task automatic apply_writes(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      int addr;
      addr = int'(tbl[i].row) * PANEL_COLS + int'(tbl[i].col);
      @(negedge clk);
      write         = 1'b1;
      px_data       = tbl[i].px;
      row           = tbl[i].row;
      column        = tbl[i].col;
      image_overlay = tbl[i].ovl;
      image_palette = tbl[i].pal;
      if (tbl[i].ovl) begin
        model_ovl[addr] = tbl[i].px;
      end else begin
        model_img[addr] = tbl[i].px;
      end
      model_pattern = tbl[i].pal;
    end
    @(negedge clk);
    write = 1'b0;
  endtask

  task automatic check_reset_outputs();
    check_level("oe_n", 1'b1, oe_n);
    check_level("latch", 1'b0, latch);
    check_level("screen_clk", 1'b0, screen_clk);
    check_row("abcde", '0, abcde);
  endtask

  task automatic wait_latch();
    @(negedge clk);
    while (!latch) begin
      @(negedge clk);
    end
  endtask

  // called on the latch cycle, ends on the first cycle with oe_n high again
  task automatic count_on_time(output int n);
    n = 0;
    @(negedge clk);
    while (!oe_n) begin
      n++;
      @(negedge clk);
    end
  endtask

  task automatic check_shift(input int r, input int p);
    logic prev;
    int   c;
    prev = 1'b0;
    c    = 0;
    while (c < PANEL_COLS) begin
      @(negedge clk);
      if (screen_clk && !prev) begin
        check_rgb($sformatf("rgb0 row %0d col %0d plane %0d", r, c, p),
                  expected_rgb(fused_pixel(r, c), p), rgb0);
        check_rgb($sformatf("rgb1 row %0d col %0d plane %0d", r + SCAN_ROWS, c, p),
                  expected_rgb(fused_pixel(r + SCAN_ROWS, c), p), rgb1);
        c++;
      end
      prev = screen_clk;
    end
  endtask

  // first latch of row pair 31 is plane 0, track it through plane 2
  task automatic sync_scan();
    int n;
    @(negedge clk);
    while (!(latch && abcde == scan_row_t'(SCAN_ROWS - 1))) begin
      @(negedge clk);
    end
    count_on_time(n);
    check_count("oe_n low cycles row 31 plane 0", BASE_ON, n);
    for (int p = 1; p < NUM_PLANES; p++) begin
      wait_latch();
      check_row("abcde", scan_row_t'(SCAN_ROWS - 1), abcde);
      count_on_time(n);
      check_count($sformatf("oe_n low cycles row 31 plane %0d", p), BASE_ON << p, n);
    end
  endtask

  task automatic check_frame(input logic writes_at_end);
    int n;
    for (int r = 0; r < SCAN_ROWS; r++) begin
      for (int p = 0; p < NUM_PLANES; p++) begin
        check_shift(r, p);
        wait_latch();
        check_row($sformatf("abcde plane %0d", p), scan_row_t'(r), abcde);
        if (writes_at_end && r == SCAN_ROWS - 1 && p == NUM_PLANES - 1) begin
          // last row is already buffered, the next fetch sees the new writes
          fork
            apply_writes(PH1_LEN, TBL_LEN - 1);
            count_on_time(n);
          join
        end else begin
          count_on_time(n);
        end
        check_count($sformatf("oe_n low cycles row %0d plane %0d", r, p), BASE_ON << p, n);
      end
    end
  endtask

  initial begin
    int unsigned seed_val;
    rst           = 1'b1;
    write         = 1'b0;
    px_data       = '0;
    column        = '0;
    row           = '0;
    image_palette = 1'b0;
    image_overlay = 1'b0;
    model_pattern = 1'b0;
    for (int i = 0; i < VRAM_DEPTH; i++) begin
      model_img[i] = '0;
      model_ovl[i] = '0;
    end
    seed_val = $urandom(RAND_SEED);
    fill_table();

    repeat (3) begin
      @(negedge clk);
      check_reset_outputs();
    end
    rst = 1'b0;
    @(negedge clk);
    check_reset_outputs();

    apply_writes(0, PH1_LEN - 1);
    sync_scan();
    check_frame(1'b1);   // image, overlay and random pixels
    check_frame(1'b0);   // pattern background under the overlay

    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/hub75_gpu.sv
`timescale 1ns/1ps
`default_nettype none

module hub75_gpu
  import gpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      write,
  input  pixel_t    px_data,
  input  coord_t    column,
  input  coord_t    row,
  input  logic      image_palette,
  input  logic      image_overlay,

  output rgb_t      rgb0,
  output rgb_t      rgb1,
  output logic      screen_clk,
  output scan_row_t abcde,
  output logic      latch,
  output logic      oe_n
);

  logic      rd;
  vaddr_t    rd_addr;
  pixel_t    pixel;

  logic      fetch_start;
  scan_row_t fetch_row;
  logic      fetch_done;

  logic      show_start;
  scan_row_t show_row;
  plane_t    show_plane;
  logic      show_done;

  coord_t    col;
  plane_t    plane;
  rgb_t      rgb_top;
  rgb_t      rgb_bot;

  pixel_store u_pixel_store (
    .clk           (clk),
    .rst           (rst),
    .write         (write),
    .px_data       (px_data),
    .column        (column),
    .row           (row),
    .image_palette (image_palette),
    .image_overlay (image_overlay),
    .rd            (rd),
    .rd_addr       (rd_addr),
    .pixel         (pixel)
  );

  row_buffer u_row_buffer (
    .clk         (clk),
    .rst         (rst),
    .fetch_start (fetch_start),
    .fetch_row   (fetch_row),
    .fetch_done  (fetch_done),
    .col         (col),
    .plane       (plane),
    .rgb_top     (rgb_top),
    .rgb_bot     (rgb_bot),
    .rd          (rd),
    .rd_addr     (rd_addr),
    .pixel       (pixel)
  );

  scan_control u_scan_control (
    .clk         (clk),
    .rst         (rst),
    .fetch_start (fetch_start),
    .fetch_row   (fetch_row),
    .fetch_done  (fetch_done),
    .show_start  (show_start),
    .show_row    (show_row),
    .show_plane  (show_plane),
    .show_done   (show_done)
  );

  hub75_driver u_hub75_driver (
    .clk        (clk),
    .rst        (rst),
    .show_start (show_start),
    .show_row   (show_row),
    .show_plane (show_plane),
    .show_done  (show_done),
    .col        (col),
    .plane      (plane),
    .rgb_top    (rgb_top),
    .rgb_bot    (rgb_bot),
    .rgb0       (rgb0),
    .rgb1       (rgb1),
    .screen_clk (screen_clk),
    .abcde      (abcde),
    .latch      (latch),
    .oe_n       (oe_n)
  );

endmodule

`default_nettype wire

// File: hub75/hub75_driver.sv
`timescale 1ns/1ps
`default_nettype none

module hub75_driver
  import gpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      show_start,
  input  scan_row_t show_row,
  input  plane_t    show_plane,
  output logic      show_done,

  output coord_t    col,
  output plane_t    plane,
  input  rgb_t      rgb_top,
  input  rgb_t      rgb_bot,

  output rgb_t      rgb0,
  output rgb_t      rgb1,
  output logic      screen_clk,
  output scan_row_t abcde,
  output logic      latch,
  output logic      oe_n
);

  logic [7:0] ph;      // cycle index in shift and latch, 0 when idle
  logic [6:0] on_cnt;  // enable cycles left
  plane_t     plane_q;
  scan_row_t  row_q;

  // column of the next shift cycle, plane taken from the strobe itself
  assign col   = ph[6:1];
  assign plane = show_start ? show_plane : plane_q;

  // ----------------------------------------------------------------------
  // shift, latch and show sequence
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      ph         <= '0;
      on_cnt     <= '0;
      plane_q    <= '0;
      row_q      <= '0;
      show_done  <= 1'b0;
      rgb0       <= '0;
      rgb1       <= '0;
      screen_clk <= 1'b0;
      abcde      <= '0;
      latch      <= 1'b0;
      oe_n       <= 1'b1;
    end else begin
      show_done <= 1'b0;
      latch     <= 1'b0;
      if (show_start) begin
        ph         <= 8'd1;
        plane_q    <= show_plane;
        row_q      <= show_row;
        screen_clk <= 1'b0;
        rgb0       <= rgb_top;  // column 0
        rgb1       <= rgb_bot;
      end else if (ph != '0) begin
        if (ph == 8'(LATCH_CYCLE)) begin
          ph     <= '0;
          oe_n   <= 1'b0;
          on_cnt <= 7'(BASE_ON) << plane_q;
        end else begin
          ph         <= ph + 8'd1;
          screen_clk <= ph[0];  // rises on even cycles
          if (ph == 8'(SHIFT_CYCLES)) begin
            latch <= 1'b1;
            abcde <= row_q;
          end else if (!ph[0]) begin
            rgb0 <= rgb_top;  // next column
            rgb1 <= rgb_bot;
          end
        end
      end else if (!oe_n) begin
        on_cnt <= on_cnt - 7'd1;
        if (on_cnt == 7'd1) begin
          oe_n      <= 1'b1;
          show_done <= 1'b1;
        end
      end
    end
  end

  a_latch_dark: assert property (
    @(posedge clk) disable iff (rst) latch |-> oe_n
  ) else $error("latch while LEDs are enabled");

endmodule

`default_nettype wire

// File: rtl/scan_control.sv
`timescale 1ns/1ps
`default_nettype none

module scan_control
  import gpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  output logic      fetch_start,
  output scan_row_t fetch_row,
  input  logic      fetch_done,

  output logic      show_start,
  output scan_row_t show_row,
  output plane_t    show_plane,
  input  logic      show_done
);

  localparam scan_row_t LAST_ROW   = scan_row_t'(SCAN_ROWS - 1);
  localparam plane_t    LAST_PLANE = plane_t'(NUM_PLANES - 1);

  scan_state_t state;
  scan_row_t   cur_row;
  plane_t      cur_plane;

  // starts in SC_NEXT on the last row, so the first fetch is row 0
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= SC_NEXT;
      cur_row   <= LAST_ROW;
      cur_plane <= '0;
    end else begin
      unique case (state)
        SC_FETCH: begin
          state <= SC_FETCH_WAIT;
        end
        SC_FETCH_WAIT: begin
          if (fetch_done) begin
            cur_plane <= '0;
            state     <= SC_SHOW;
          end
        end
        SC_SHOW: begin
          state <= SC_SHOW_WAIT;
        end
        SC_SHOW_WAIT: begin
          if (show_done) begin
            if (cur_plane == LAST_PLANE) begin
              state <= SC_NEXT;
            end else begin
              cur_plane <= cur_plane + 2'd1;
              state     <= SC_SHOW;
            end
          end
        end
        SC_NEXT: begin
          cur_row <= (cur_row == LAST_ROW) ? '0 : cur_row + 5'd1;
          state   <= SC_FETCH;
        end
        default: begin
          state <= SC_NEXT;
        end
      endcase
    end
  end

  assign fetch_start = (state == SC_FETCH);
  assign show_start  = (state == SC_SHOW);
  assign fetch_row   = cur_row;
  assign show_row    = cur_row;
  assign show_plane  = cur_plane;

  a_done_expected: assert property (
    @(posedge clk) disable iff (rst)
      !(fetch_done && state != SC_FETCH_WAIT) && !(show_done && state != SC_SHOW_WAIT)
  ) else $error("done strobe outside its wait state");

endmodule

`default_nettype wire

// File: rtl/row_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module row_buffer
  import gpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      fetch_start,
  input  scan_row_t fetch_row,
  output logic      fetch_done,

  input  coord_t    col,
  input  plane_t    plane,
  output rgb_t      rgb_top,
  output rgb_t      rgb_bot,

  output logic      rd,
  output vaddr_t    rd_addr,
  input  pixel_t    pixel
);

  localparam logic [6:0] LAST_READ = 7'(FETCH_READS - 1);

  logic       busy;
  logic [6:0] rd_cnt;  // bit 6 picks the bottom row
  scan_row_t  row_q;
  logic       rd_q;
  logic [6:0] idx_q;

  pixel_t top_buf [0:PANEL_COLS-1];
  pixel_t bot_buf [0:PANEL_COLS-1];

  function automatic rgb_t plane_bits(input pixel_t px, input plane_t p);
    rgb_t bits;
    case (p)
      2'd0:    bits = {1'b0, px[2], px[5]};
      2'd1:    bits = {px[0], px[3], px[6]};
      default: bits = {px[1], px[4], px[7]};
    endcase
    return bits;
  endfunction

  // ----------------------------------------------------------------------
  // read sequencer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      rd_cnt     <= '0;
      rd_q       <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      rd_q       <= busy;
      fetch_done <= rd_q && (idx_q == LAST_READ);  // last pixel stored this cycle
      if (fetch_start) begin
        busy   <= 1'b1;
        rd_cnt <= '0;
      end else if (busy) begin
        rd_cnt <= rd_cnt + 7'd1;
        if (rd_cnt == LAST_READ) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_start) begin
      row_q <= fetch_row;
    end
    idx_q <= rd_cnt;
  end

  assign rd      = busy;
  assign rd_addr = {rd_cnt[6], row_q, rd_cnt[5:0]};  // bottom row is row + 32

  // ----------------------------------------------------------------------
  // line buffers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rd_q) begin
      if (idx_q[6]) begin
        bot_buf[idx_q[5:0]] <= pixel;
      end else begin
        top_buf[idx_q[5:0]] <= pixel;
      end
    end
  end

  assign rgb_top = plane_bits(top_buf[col], plane);
  assign rgb_bot = plane_bits(bot_buf[col], plane);

  a_no_fetch_overlap: assert property (
    @(posedge clk) disable iff (rst) fetch_start |-> !busy && !rd_q
  ) else $error("fetch_start during a running fetch");

endmodule

`default_nettype wire

// File: vram/pixel_store.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_store
  import gpu_pkg::*;
(
  input  logic   clk,
  input  logic   rst,

  input  logic   write,
  input  pixel_t px_data,
  input  coord_t column,
  input  coord_t row,
  input  logic   image_palette,
  input  logic   image_overlay,

  input  logic   rd,
  input  vaddr_t rd_addr,
  output pixel_t pixel
);

  logic   wr_q;
  logic   wr_ovl_q;
  pixel_t wr_data_q;
  vaddr_t wr_addr_q;
  logic   bg_pattern;  // 1 selects the built-in pattern

  logic   wr_image;
  logic   wr_overlay;

  vaddr_t rd_addr_q;
  pixel_t image_px;
  pixel_t overlay_px;
  pixel_t pattern_px;
  pixel_t bg_px;

  // ----------------------------------------------------------------------
  // host write path
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q       <= 1'b0;
      bg_pattern <= 1'b0;
    end else begin
      wr_q <= write;
      if (write) begin
        bg_pattern <= image_palette;  // every write picks the background
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_ovl_q  <= image_overlay;
    wr_data_q <= px_data;
    wr_addr_q <= {row, column};
  end

  assign wr_image   = wr_q & ~wr_ovl_q;
  assign wr_overlay = wr_q & wr_ovl_q;

  vram u_vram_image (
    .clk     (clk),
    .wr      (wr_image),
    .wr_addr (wr_addr_q),
    .wr_data (wr_data_q),
    .rd      (rd),
    .rd_addr (rd_addr),
    .rd_data (image_px)
  );

  vram u_vram_overlay (
    .clk     (clk),
    .wr      (wr_overlay),
    .wr_addr (wr_addr_q),
    .wr_data (wr_data_q),
    .rd      (rd),
    .rd_addr (rd_addr),
    .rd_data (overlay_px)
  );

  // ----------------------------------------------------------------------
  // read side, pattern and fusion
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rd) begin
      rd_addr_q <= rd_addr;  // lines up with the memory data
    end
  end

  assign pattern_px = {rd_addr_q[8:6], rd_addr_q[4:0]};  // row 2..0, column 4..0
  assign bg_px      = bg_pattern ? pattern_px : image_px;
  assign pixel      = (overlay_px != '0) ? overlay_px : bg_px;  // zero is transparent

endmodule

`default_nettype wire

// File: vram/vram.sv
`timescale 1ns/1ps
`default_nettype none

module vram
  import gpu_pkg::*;
(
  input  logic   clk,

  input  logic   wr,
  input  vaddr_t wr_addr,
  input  pixel_t wr_data,

  input  logic   rd,
  input  vaddr_t rd_addr,
  output pixel_t rd_data
);

  pixel_t mem [0:VRAM_DEPTH-1];

  // configuration contents, a blank frame
  initial begin
    for (int i = 0; i < VRAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      rd_data <= mem[rd_addr];  // valid the cycle after rd
    end
  end

  a_wr_addr_known: assert property (
    @(posedge clk) wr |-> !$isunknown(wr_addr)
  ) else $error("vram write with unknown address");

endmodule

`default_nettype wire

// File: common/gpu_pkg.sv
`default_nettype none

package gpu_pkg;

  // ----------------------------------------------------------------------
  // data widths
  // ----------------------------------------------------------------------
  typedef logic [7:0]  pixel_t;    // rgb332, red 7..5, green 4..2, blue 1..0
  typedef logic [5:0]  coord_t;    // column or row
  typedef logic [11:0] vaddr_t;    // row * 64 + column
  typedef logic [4:0]  scan_row_t; // row pair, also the ABCDE value
  typedef logic [1:0]  plane_t;    // bit plane 0..2
  typedef logic [2:0]  rgb_t;      // bit 0 red, bit 1 green, bit 2 blue

  // ----------------------------------------------------------------------
  // panel geometry and plane timing
  // ----------------------------------------------------------------------
  localparam int PANEL_COLS = 64;
  localparam int SCAN_ROWS  = 32;
  localparam int NUM_PLANES = 3;
  localparam int BASE_ON    = 16;   // plane 0 on-time in cycles

  localparam int VRAM_DEPTH   = PANEL_COLS * 2 * SCAN_ROWS;
  localparam int FETCH_READS  = 2 * PANEL_COLS;    // top row then bottom row
  localparam int SHIFT_CYCLES = 2 * PANEL_COLS;    // low and high half per column
  localparam int LATCH_CYCLE  = SHIFT_CYCLES + 1;

  typedef enum logic [2:0] {
    SC_FETCH,
    SC_FETCH_WAIT,
    SC_SHOW,
    SC_SHOW_WAIT,
    SC_NEXT
  } scan_state_t;

endpackage

`default_nettype wire
